// File: Makefile
# Verilator build and run of the peripheral hub testbench

SIM := obj_dir/Vtb_periph_hub

all: run

# Rebuilt only when a source or the file list changes
$(SIM): vlog.f $(wildcard hdl/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_hub -f vlog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: hdl/host_decode.sv
`timescale 1ns/1ps

module host_decode import periph_pkg::*; (
   input  logic               msoc_clk,
   input  logic               rstn,
   input  host_req_t          host_i,
   output logic               key_rd_o,
   output logic               key_pop_o,
   output logic               reg_wr_o,
   output logic               reg_rd_o,
   output logic               txbuf_wr_o,
   output logic               rxbuf_rd_o,
   input  logic [HOST_DW-1:0] key_rdata_i,
   input  logic [HOST_DW-1:0] reg_rdata_i,
   input  logic [HOST_DW-1:0] rxbuf_rdata_i,
   output logic [HOST_DW-1:0] hid_rddata_o
);

   logic       req_rd, req_wr;
   logic [1:0] region;
   logic       rd_vld_q;
   logic [1:0] rd_region_q;

   assign region = host_i.addr[HOST_AW-1:HOST_AW-2];
   assign req_wr = host_i.en & (|host_i.we);   // Any byte lane makes a write
   assign req_rd = host_i.en & ~(|host_i.we);

   assign key_rd_o   = req_rd & (region == REGION_KEY);
   assign key_pop_o  = req_wr & (region == REGION_KEY);   // Write to the queue pops
   assign reg_rd_o   = req_rd & (region == REGION_SD);
   assign reg_wr_o   = req_wr & (region == REGION_SD) & ~host_i.addr[SD_TXBUF_BIT];
   assign txbuf_wr_o = req_wr & (region == REGION_SD) & host_i.addr[SD_TXBUF_BIT];
   assign rxbuf_rd_o = req_rd & (region == REGION_RXBUF);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rd_vld_q    <= 1'b0;
         rd_region_q <= REGION_KEY;
      end
      else
      begin
         rd_vld_q    <= req_rd;   // Sources return data one cycle on
         rd_region_q <= region;
      end
   end

   always_comb
   begin
      hid_rddata_o = '0;
      if (rd_vld_q)
      begin
         case (rd_region_q)
            REGION_KEY:   hid_rddata_o = key_rdata_i;
            REGION_FB:    hid_rddata_o = '0;
            REGION_SD:    hid_rddata_o = reg_rdata_i;
            REGION_RXBUF: hid_rddata_o = rxbuf_rdata_i;
            default:      hid_rddata_o = '0;
         endcase
      end
   end

endmodule

// File: hdl/key_fifo.sv
`timescale 1ns/1ps

module key_fifo import periph_pkg::*; #(
   parameter int KEY_DEPTH = 16   // Power of two, pointers wrap naturally
) (
   input  logic               msoc_clk,
   input  logic               rstn,
   input  logic               push_i,
   input  key_entry_t         entry_i,
   input  logic               pop_i,
   input  logic               rd_i,
   output logic [HOST_DW-1:0] rdata_o
);

   localparam int PTR_W = $clog2(KEY_DEPTH);

   key_entry_t       mem [KEY_DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [PTR_W:0]   count;
   logic             push_q;
   key_entry_t       entry_q;
   logic             empty, full;
   logic             do_push, do_pop;

   assign empty   = (count == '0);
   assign full    = (count == (PTR_W+1)'(KEY_DEPTH));
   assign do_push = push_q & ~full;   // Lost when full
   assign do_pop  = pop_i & ~empty;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         push_q <= 1'b0;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         push_q <= push_i;
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      entry_q <= entry_i;   // Decoder entry lands one cycle after the strobe
      if (do_push)
         mem[wr_ptr] <= entry_q;
   end

   // Head and empty flag as seen in the request cycle
   always_ff @(posedge msoc_clk)
   begin
      if (rd_i)
         rdata_o <= {15'b0, empty, 1'b0, mem[rd_ptr]};
   end

endmodule

// File: hdl/periph_hub.sv
`timescale 1ns/1ps

module periph_hub import periph_pkg::*; #(
   parameter int BUF_AW    = 9,
   parameter int KEY_DEPTH = 16
) (
   input  logic               msoc_clk,
   input  logic               rstn,
   input  host_req_t          host_i,
   output logic [HOST_DW-1:0] hid_rddata_o,
   input  logic               key_valid_i,
   input  key_entry_t         key_entry_i,
   output sd_cfg_t            sd_cfg_o,
   input  sd_stat_t           sd_stat_i,
   input  logic [15:0]        dip_i,
   output logic [7:0]         led_o,
   input  logic [BUF_AW-1:0]  sd_buf_addr_i,
   input  logic               sd_tx_rd_i,
   output logic [HOST_DW-1:0] sd_tx_data_o,
   input  logic               sd_rx_wr_i,
   input  logic [HOST_DW-1:0] sd_rx_data_i
);

   logic               key_rd, key_pop;
   logic               reg_wr, reg_rd;
   logic               txbuf_wr, rxbuf_rd;
   logic [HOST_DW-1:0] key_rdata, reg_rdata, rxbuf_rdata;
   logic [BUF_AW-1:0]  host_word_addr;

   assign host_word_addr = host_i.addr[BUF_AW+1:2];   // Word address of host access

   host_decode decode_i (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .host_i        (host_i),
      .key_rd_o      (key_rd),
      .key_pop_o     (key_pop),
      .reg_wr_o      (reg_wr),
      .reg_rd_o      (reg_rd),
      .txbuf_wr_o    (txbuf_wr),
      .rxbuf_rd_o    (rxbuf_rd),
      .key_rdata_i   (key_rdata),
      .reg_rdata_i   (reg_rdata),
      .rxbuf_rdata_i (rxbuf_rdata),
      .hid_rddata_o  (hid_rddata_o)
   );

   key_fifo #(.KEY_DEPTH(KEY_DEPTH)) key_fifo_i (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (key_valid_i),
      .entry_i  (key_entry_i),
      .pop_i    (key_pop),
      .rd_i     (key_rd),
      .rdata_o  (key_rdata)
   );

   sd_ctrl_regs regs_i (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .wr_i      (reg_wr),
      .rd_i      (reg_rd),
      .addr_i    (host_i.addr),
      .wdata_i   (host_i.wdata),
      .rdata_o   (reg_rdata),
      .sd_cfg_o  (sd_cfg_o),
      .sd_stat_i (sd_stat_i),
      .dip_i     (dip_i),
      .led_o     (led_o)
   );

   // Host writes port A, engine reads port B
   sd_block_buf #(.BUF_AW(BUF_AW)) tx_buf_i (
      .msoc_clk  (msoc_clk),
      .a_en_i    (txbuf_wr),
      .a_we_i    (txbuf_wr),
      .a_addr_i  (host_word_addr),
      .a_wdata_i (host_i.wdata),
      .a_rdata_o (),
      .b_en_i    (sd_tx_rd_i),
      .b_we_i    (1'b0),
      .b_addr_i  (sd_buf_addr_i),
      .b_wdata_i ('0),
      .b_rdata_o (sd_tx_data_o)
   );

   // Engine writes port A, host reads port B
   sd_block_buf #(.BUF_AW(BUF_AW)) rx_buf_i (
      .msoc_clk  (msoc_clk),
      .a_en_i    (sd_rx_wr_i),
      .a_we_i    (sd_rx_wr_i),
      .a_addr_i  (sd_buf_addr_i),
      .a_wdata_i (sd_rx_data_i),
      .a_rdata_o (),
      .b_en_i    (rxbuf_rd),
      .b_we_i    (1'b0),
      .b_addr_i  (host_word_addr),
      .b_wdata_i ('0),
      .b_rdata_o (rxbuf_rdata)
   );

endmodule

// File: hdl/periph_pkg.sv
package periph_pkg;

   localparam int HOST_AW = 17;
   localparam int HOST_DW = 32;

   // Region select from host address bits 16:15
   localparam logic [1:0] REGION_KEY   = 2'd0;
   localparam logic [1:0] REGION_FB    = 2'd1;   // Frame store removed, reads zero
   localparam logic [1:0] REGION_SD    = 2'd2;
   localparam logic [1:0] REGION_RXBUF = 2'd3;

   localparam int SD_TXBUF_BIT = 14;   // Region 2: tx buffer when set

   // Write side register indexes, address bits 5:2
   localparam logic [3:0] SD_REG_ALIGN   = 4'd0;
   localparam logic [3:0] SD_REG_ARG     = 4'd2;
   localparam logic [3:0] SD_REG_CMD     = 4'd3;
   localparam logic [3:0] SD_REG_SETTING = 4'd4;
   localparam logic [3:0] SD_REG_START   = 4'd5;
   localparam logic [3:0] SD_REG_RESETS  = 4'd6;
   localparam logic [3:0] SD_REG_BLKCNT  = 4'd7;
   localparam logic [3:0] SD_REG_BLKSIZE = 4'd8;
   localparam logic [3:0] SD_REG_TIMEOUT = 4'd9;
   localparam logic [3:0] SD_REG_LED     = 4'd15;

   // Readback indexes, address bits 6:2
   localparam logic [4:0] RB_RESP0     = 5'd0;
   localparam logic [4:0] RB_RESP1     = 5'd1;
   localparam logic [4:0] RB_RESP2     = 5'd2;
   localparam logic [4:0] RB_RESP3     = 5'd3;
   localparam logic [4:0] RB_CMD_WAIT  = 5'd4;
   localparam logic [4:0] RB_STATUS    = 5'd5;
   localparam logic [4:0] RB_DATA_WAIT = 5'd8;
   localparam logic [4:0] RB_TRANSF    = 5'd9;
   localparam logic [4:0] RB_DETECT    = 5'd12;
   localparam logic [4:0] RB_CFG_BASE  = 5'd16;   // Mirrors write index n at 16+n
   localparam logic [4:0] RB_DIP       = 5'd31;

   localparam logic [HOST_DW-1:0] RB_UNMAPPED = 32'hDEADBEEF;

   typedef struct packed {
      logic [6:0] ascii;
      logic [7:0] scan;
   } key_entry_t;

   typedef struct packed {
      logic               en;
      logic [3:0]         we;
      logic [HOST_AW-1:0] addr;
      logic [HOST_DW-1:0] wdata;
   } host_req_t;

   typedef struct packed {
      logic sd_reset;
      logic clk_rst;
      logic data_rst;
      logic cmd_rst;
   } sd_resets_t;

   typedef struct packed {
      logic [1:0]  align;
      logic [5:0]  cmd;
      logic [31:0] arg;
      logic [2:0]  setting;
      logic [2:0]  data_start;
      logic        start;
      logic [15:0] blkcnt;
      logic [11:0] blksize;
      logic [31:0] timeout;
      sd_resets_t  resets;
   } sd_cfg_t;

   typedef struct packed {
      logic [3:0][31:0] response;
      logic [31:0]      status;
      logic [31:0]      cmd_wait;
      logic [31:0]      data_wait;
      logic [15:0]      transf_cnt;
      logic             detect;
   } sd_stat_t;

endpackage

// File: hdl/sd_block_buf.sv
`timescale 1ns/1ps

module sd_block_buf import periph_pkg::*; #(
   parameter int BUF_AW = 9
) (
   input  logic               msoc_clk,
   input  logic               a_en_i,
   input  logic               a_we_i,
   input  logic [BUF_AW-1:0]  a_addr_i,
   input  logic [HOST_DW-1:0] a_wdata_i,
   output logic [HOST_DW-1:0] a_rdata_o,
   input  logic               b_en_i,
   input  logic               b_we_i,
   input  logic [BUF_AW-1:0]  b_addr_i,
   input  logic [HOST_DW-1:0] b_wdata_i,
   output logic [HOST_DW-1:0] b_rdata_o
);

   localparam int DEPTH = 2 ** BUF_AW;

   logic [HOST_DW-1:0] mem [DEPTH];

   // Both ports in one process, port B wins on a same-address write
   always_ff @(posedge msoc_clk)
   begin
      if (a_en_i)
      begin
         a_rdata_o <= mem[a_addr_i];   // Read before write
         if (a_we_i)
            mem[a_addr_i] <= a_wdata_i;
      end
      if (b_en_i)
      begin
         b_rdata_o <= mem[b_addr_i];
         if (b_we_i)
            mem[b_addr_i] <= b_wdata_i;
      end
   end

endmodule

// File: hdl/sd_ctrl_regs.sv
`timescale 1ns/1ps

module sd_ctrl_regs import periph_pkg::*; (
   input  logic               msoc_clk,
   input  logic               rstn,
   input  logic               wr_i,
   input  logic               rd_i,
   input  logic [HOST_AW-1:0] addr_i,
   input  logic [HOST_DW-1:0] wdata_i,
   output logic [HOST_DW-1:0] rdata_o,
   output sd_cfg_t            sd_cfg_o,
   input  sd_stat_t           sd_stat_i,
   input  logic [15:0]        dip_i,
   output logic [7:0]         led_o
);

   logic [3:0]  wr_idx;
   logic [4:0]  rd_idx;
   sd_cfg_t     cfg_q;
   logic [7:0]  led_q;
   sd_stat_t    stat_q;
   logic [15:0] dip_q;

   assign wr_idx   = addr_i[5:2];
   assign rd_idx   = addr_i[6:2];
   assign sd_cfg_o = cfg_q;
   assign led_o    = led_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         cfg_q <= '0;
         led_q <= '0;
      end
      else if (wr_i)
      begin
         case (wr_idx)
            SD_REG_ALIGN:   cfg_q.align <= wdata_i[1:0];
            SD_REG_ARG:     cfg_q.arg <= wdata_i;
            SD_REG_CMD:     cfg_q.cmd <= wdata_i[5:0];
            SD_REG_SETTING: {cfg_q.data_start, cfg_q.setting} <= wdata_i[5:0];
            SD_REG_START:   cfg_q.start <= wdata_i[0];   // Level, cleared by software
            SD_REG_RESETS:  cfg_q.resets <= sd_resets_t'(wdata_i[3:0]);
            SD_REG_BLKCNT:  cfg_q.blkcnt <= wdata_i[15:0];
            SD_REG_BLKSIZE: cfg_q.blksize <= wdata_i[11:0];
            SD_REG_TIMEOUT: cfg_q.timeout <= wdata_i;
            SD_REG_LED:     led_q <= wdata_i[7:0];   // Activity LEDs
            default:        cfg_q <= cfg_q;
         endcase
      end
   end

   // Engine status and switches sampled every cycle
   always_ff @(posedge msoc_clk)
   begin
      stat_q <= sd_stat_i;
      dip_q  <= dip_i;
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rd_i)
      begin
         case (rd_idx)
            RB_RESP0:
               rdata_o <= stat_q.response[0];
            RB_RESP1:
               rdata_o <= stat_q.response[1];
            RB_RESP2:
               rdata_o <= stat_q.response[2];
            RB_RESP3:
               rdata_o <= stat_q.response[3];
            RB_CMD_WAIT:
               rdata_o <= stat_q.cmd_wait;
            RB_STATUS:
               rdata_o <= stat_q.status;
            RB_DATA_WAIT:
               rdata_o <= stat_q.data_wait;
            RB_TRANSF:
               rdata_o <= {16'b0, stat_q.transf_cnt};
            RB_DETECT:
               rdata_o <= {31'b0, stat_q.detect};
            // Configuration mirror
            RB_CFG_BASE + 5'(SD_REG_ALIGN):
               rdata_o <= {30'b0, cfg_q.align};
            RB_CFG_BASE + 5'(SD_REG_ARG):
               rdata_o <= cfg_q.arg;
            RB_CFG_BASE + 5'(SD_REG_CMD):
               rdata_o <= {26'b0, cfg_q.cmd};
            RB_CFG_BASE + 5'(SD_REG_SETTING):
               rdata_o <= {26'b0, cfg_q.data_start, cfg_q.setting};
            RB_CFG_BASE + 5'(SD_REG_START):
               rdata_o <= {31'b0, cfg_q.start};
            RB_CFG_BASE + 5'(SD_REG_RESETS):
               rdata_o <= {28'b0, cfg_q.resets};
            RB_CFG_BASE + 5'(SD_REG_BLKCNT):
               rdata_o <= {16'b0, cfg_q.blkcnt};
            RB_CFG_BASE + 5'(SD_REG_BLKSIZE):
               rdata_o <= {20'b0, cfg_q.blksize};
            RB_CFG_BASE + 5'(SD_REG_TIMEOUT):
               rdata_o <= cfg_q.timeout;
            RB_DIP:
               rdata_o <= {16'b0, dip_q};   // Boot options from switches
            default:
               rdata_o <= RB_UNMAPPED;
         endcase
      end
   end

endmodule

// File: verif/periph_checker.sv
`timescale 1ns/1ps

module periph_checker import periph_pkg::*; #(
   parameter int BUF_AW    = 9,
   parameter int KEY_DEPTH = 16
) (
   input  logic               msoc_clk,
   input  logic               rstn,
   input  logic               done_i,
   input  host_req_t          host_i,
   input  logic               key_valid_i,
   input  key_entry_t         key_entry_i,
   input  sd_stat_t           sd_stat_i,
   input  logic [15:0]        dip_i,
   input  logic [BUF_AW-1:0]  sd_buf_addr_i,
   input  logic               sd_tx_rd_i,
   input  logic               sd_rx_wr_i,
   input  logic [HOST_DW-1:0] sd_rx_data_i,
   input  logic [HOST_DW-1:0] hid_rddata_i,
   input  sd_cfg_t            sd_cfg_i,
   input  logic [7:0]         led_i,
   input  logic [HOST_DW-1:0] sd_tx_data_i,
   output int                 err_cnt_o
);

   key_entry_t         kq [$];   // Head at index 0
   logic               push_m;
   key_entry_t         entry_m;
   sd_cfg_t            cfg_m;
   logic [7:0]         led_m;
   sd_stat_t           stat_m;
   logic [15:0]        dip_m;
   logic [HOST_DW-1:0] tx_m [int];
   logic [HOST_DW-1:0] rx_m [int];
   logic [HOST_DW-1:0] rd_exp;
   logic [HOST_DW-1:0] rd_mask;
   logic [HOST_DW-1:0] tx_exp;
   logic               tx_pend;
   int                 err_cnt = 0;
   int                 chk_cnt = 0;
   int                 rd_cnt = 0;
   int                 lost_cnt = 0;

   assign err_cnt_o = err_cnt;

   function automatic logic [HOST_DW-1:0] readback(logic [4:0] idx);
      case (idx)
         RB_RESP0, RB_RESP1, RB_RESP2, RB_RESP3: return stat_m.response[idx[1:0]];
         RB_CMD_WAIT:  return stat_m.cmd_wait;
         RB_STATUS:    return stat_m.status;
         RB_DATA_WAIT: return stat_m.data_wait;
         RB_TRANSF:    return {16'b0, stat_m.transf_cnt};
         RB_DETECT:    return {31'b0, stat_m.detect};
         5'd16:        return {30'b0, cfg_m.align};
         5'd18:        return cfg_m.arg;
         5'd19:        return {26'b0, cfg_m.cmd};
         5'd20:        return {26'b0, cfg_m.data_start, cfg_m.setting};
         5'd21:        return {31'b0, cfg_m.start};
         5'd22:        return {28'b0, cfg_m.resets};
         5'd23:        return {16'b0, cfg_m.blkcnt};
         5'd24:        return {20'b0, cfg_m.blksize};
         5'd25:        return cfg_m.timeout;
         RB_DIP:       return {16'b0, dip_m};
         default:      return RB_UNMAPPED;
      endcase
   endfunction

   task automatic write_reg(logic [3:0] idx, logic [HOST_DW-1:0] d);
      case (idx)
         SD_REG_ALIGN:   cfg_m.align = d[1:0];
         SD_REG_ARG:     cfg_m.arg = d;
         SD_REG_CMD:     cfg_m.cmd = d[5:0];
         SD_REG_SETTING:
         begin
            cfg_m.setting    = d[2:0];
            cfg_m.data_start = d[5:3];
         end
         SD_REG_START:   cfg_m.start = d[0];
         SD_REG_RESETS:  cfg_m.resets = d[3:0];
         SD_REG_BLKCNT:  cfg_m.blkcnt = d[15:0];
         SD_REG_BLKSIZE: cfg_m.blksize = d[11:0];
         SD_REG_TIMEOUT: cfg_m.timeout = d;
         SD_REG_LED:     led_m = d[7:0];
         default:        ;
      endcase
   endtask

   task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   // Applies the inputs that the next rising edge will sample
   task automatic step_model();
      logic       rd;
      logic       wr;
      logic [1:0] region;
      int         buf_word;
      bit         full_m;
      rd       = host_i.en && (host_i.we == 4'b0);
      wr       = host_i.en && (host_i.we != 4'b0);
      region   = host_i.addr[16:15];
      buf_word = int'(host_i.addr[BUF_AW+1:2]);
      rd_exp   = '0;
      rd_mask  = '1;
      if (rd)
      begin
         rd_cnt++;
         case (region)
            REGION_KEY:
            begin
               if (kq.size() == 0)
               begin
                  rd_exp  = 32'h0001_0000;   // Empty flag only, head undefined
                  rd_mask = 32'hFFFF_8000;
               end
               else
                  rd_exp = {17'b0, kq[0]};
            end
            REGION_SD:
               rd_exp = readback(host_i.addr[6:2]);
            REGION_RXBUF:
            begin
               if (rx_m.exists(buf_word))
                  rd_exp = rx_m[buf_word];
               else
                  rd_mask = '0;   // Word never written
            end
            default:
               rd_exp = '0;
         endcase
      end
      tx_pend = sd_tx_rd_i && tx_m.exists(int'(sd_buf_addr_i));
      if (tx_pend)
         tx_exp = tx_m[int'(sd_buf_addr_i)];   // Old word on a same-cycle write
      if (wr && region == REGION_SD)
      begin
         if (host_i.addr[SD_TXBUF_BIT])
            tx_m[buf_word] = host_i.wdata;
         else
            write_reg(host_i.addr[5:2], host_i.wdata);
      end
      if (sd_rx_wr_i)
         rx_m[int'(sd_buf_addr_i)] = sd_rx_data_i;
      full_m = (kq.size() >= KEY_DEPTH);
      if (wr && region == REGION_KEY && kq.size() > 0)
         void'(kq.pop_front());
      if (push_m && full_m)
         lost_cnt++;
      else if (push_m)
         kq.push_back(entry_m);
      push_m  = key_valid_i;   // Entry lands one cycle after the strobe
      entry_m = key_entry_i;
      stat_m  = sd_stat_i;
      dip_m   = dip_i;
   endtask

   // Outputs settle after the rising edge, inputs change just after it
   always @(negedge msoc_clk)
   begin
      if (!rstn)
      begin
         kq.delete();
         push_m  = 1'b0;
         cfg_m   = '0;
         led_m   = '0;
         rd_exp  = '0;
         rd_mask = '1;
         tx_pend = 1'b0;
         stat_m  = sd_stat_i;
         dip_m   = dip_i;
      end
      else
      begin
         check_val("hid_rddata_o", hid_rddata_i & rd_mask, rd_exp & rd_mask);
         check_val("sd_cfg_o", sd_cfg_i, cfg_m);
         check_val("led_o", led_i, led_m);
         if (tx_pend)
            check_val("sd_tx_data_o", sd_tx_data_i, tx_exp);
         step_model();
      end
   end

   always @(posedge done_i)
      $display("checks %0d, errors %0d, host reads %0d, lost key pushes %0d",
               chk_cnt, err_cnt, rd_cnt, lost_cnt);

endmodule

// File: verif/periph_props.sv
`timescale 1ns/1ps

module periph_props import periph_pkg::*; (
   input logic               msoc_clk,
   input logic               rstn,
   input host_req_t          host_i,
   input logic               key_rd_i,
   input logic               key_pop_i,
   input logic               reg_wr_i,
   input logic               reg_rd_i,
   input logic               txbuf_wr_i,
   input logic               rxbuf_rd_i,
   input logic [HOST_DW-1:0] hid_rddata_i
);

   logic host_rd;
   logic host_wr;

   assign host_rd = host_i.en & ~(|host_i.we);
   assign host_wr = host_i.en & (|host_i.we);

   strobe_onehot: assert property (@(posedge msoc_clk) disable iff (!rstn)
      $onehot0({key_rd_i, key_pop_i, reg_wr_i, reg_rd_i, txbuf_wr_i, rxbuf_rd_i}))
      else $error("more than one region strobe active in one cycle");

   // Read data bus stays quiet after anything but a read
   idle_rdata_zero: assert property (@(posedge msoc_clk) disable iff (!rstn)
      !host_rd |=> (hid_rddata_i == '0))
      else $error("read data not zero after a cycle without a read");

   pop_is_write: assert property (@(posedge msoc_clk) disable iff (!rstn)
      key_pop_i |-> host_wr)
      else $error("key queue pop without a host write");

endmodule

// File: verif/tb_periph_hub.sv
`timescale 1ns/1ps

module tb_periph_hub import periph_pkg::*; ();

   localparam int BUF_AW    = 9;
   localparam int KEY_DEPTH = 16;
   localparam int RUN_CYCLES = 200 + 200 + 240 + 200 + 300;   // Sum of the phase lengths
   localparam int TOTAL_CYCLES = 4 + RUN_CYCLES + 8;
   localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;

   logic               msoc_clk;
   logic               rstn;
   host_req_t          host;
   logic [HOST_DW-1:0] hid_rddata;
   logic               key_valid;
   key_entry_t         key_entry;
   sd_cfg_t            sd_cfg;
   sd_stat_t           sd_stat;
   logic [15:0]        dip;
   logic [7:0]         led;
   logic [BUF_AW-1:0]  sd_buf_addr;
   logic               sd_tx_rd;
   logic [HOST_DW-1:0] sd_tx_data;
   logic               sd_rx_wr;
   logic [HOST_DW-1:0] sd_rx_data;
   logic               done;
   int                 err_cnt;
   int                 cycle_cnt = 0;

   periph_hub #(.BUF_AW(BUF_AW), .KEY_DEPTH(KEY_DEPTH)) dut_i (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .host_i        (host),
      .hid_rddata_o  (hid_rddata),
      .key_valid_i   (key_valid),
      .key_entry_i   (key_entry),
      .sd_cfg_o      (sd_cfg),
      .sd_stat_i     (sd_stat),
      .dip_i         (dip),
      .led_o         (led),
      .sd_buf_addr_i (sd_buf_addr),
      .sd_tx_rd_i    (sd_tx_rd),
      .sd_tx_data_o  (sd_tx_data),
      .sd_rx_wr_i    (sd_rx_wr),
      .sd_rx_data_i  (sd_rx_data)
   );

   periph_checker #(.BUF_AW(BUF_AW), .KEY_DEPTH(KEY_DEPTH)) chk_i (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .done_i        (done),
      .host_i        (host),
      .key_valid_i   (key_valid),
      .key_entry_i   (key_entry),
      .sd_stat_i     (sd_stat),
      .dip_i         (dip),
      .sd_buf_addr_i (sd_buf_addr),
      .sd_tx_rd_i    (sd_tx_rd),
      .sd_rx_wr_i    (sd_rx_wr),
      .sd_rx_data_i  (sd_rx_data),
      .hid_rddata_i  (hid_rddata),
      .sd_cfg_i      (sd_cfg),
      .led_i         (led),
      .sd_tx_data_i  (sd_tx_data),
      .err_cnt_o     (err_cnt)
   );

   bind host_decode periph_props props_i (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .host_i       (host_i),
      .key_rd_i     (key_rd_o),
      .key_pop_i    (key_pop_o),
      .reg_wr_i     (reg_wr_o),
      .reg_rd_i     (reg_rd_o),
      .txbuf_wr_i   (txbuf_wr_o),
      .rxbuf_rd_i   (rxbuf_rd_o),
      .hid_rddata_i (hid_rddata_o)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever #4 msoc_clk = ~msoc_clk;
   end

   always @(posedge msoc_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   function automatic int phase_len(int phase);
      case (phase)
         0: return 200;   // Queue filling
         1: return 200;   // Queue draining
         2: return 240;   // Register writes
         3: return 200;   // Status readback
         default: return 300;
      endcase
   endfunction

   function automatic logic [HOST_AW-1:0] make_addr(logic [1:0] region, logic txbuf, int word);
      return {region, txbuf, 14'(word << 2)};
   endfunction

   task automatic host_idle();
      host = '{en: 1'b0, we: 4'b0, addr: '0, wdata: '0};
   endtask

   task automatic host_read(logic [HOST_AW-1:0] addr);
      host = '{en: 1'b1, we: 4'b0, addr: addr, wdata: $urandom()};
   endtask

   task automatic host_write(logic [HOST_AW-1:0] addr, logic [HOST_DW-1:0] data);
      host = '{en: 1'b1, we: 4'($urandom_range(15, 1)), addr: addr, wdata: data};
   endtask

   task automatic key_step(int push_pct);
      key_valid = ($urandom_range(99) < push_pct);
      key_entry = key_entry_t'(15'($urandom()));
   endtask

   // SD engine: random buffer traffic, status mostly held between changes
   task automatic engine_step(bit stat_busy);
      sd_buf_addr = BUF_AW'($urandom_range(15));
      sd_tx_rd    = ($urandom_range(3) == 0);
      sd_rx_wr    = ($urandom_range(3) == 0);
      sd_rx_data  = $urandom();
      if (stat_busy || $urandom_range(7) == 0)
      begin
         for (int k = 0; k < 4; k++)
            sd_stat.response[k] = $urandom();
         sd_stat.status     = $urandom();
         sd_stat.cmd_wait   = $urandom();
         sd_stat.data_wait  = $urandom();
         sd_stat.transf_cnt = 16'($urandom());
         sd_stat.detect     = 1'($urandom());
         dip                = 16'($urandom());
      end
   endtask

   task automatic host_step(int phase);
      int sel;
      sel = int'($urandom_range(9));
      case (phase)
         0, 1:
         begin
            if (sel < 4)
               host_read(make_addr(REGION_KEY, 1'b0, 0));
            else if (sel < 5 + 3 * phase)   // Pops are rare while filling
               host_write(make_addr(REGION_KEY, 1'b0, 0), $urandom());
            else
               host_idle();
         end
         2:
         begin
            if (sel < 5)
               host_write(make_addr(REGION_SD, 1'b0, int'($urandom_range(31))), $urandom());
            else if (sel < 8)
               host_read(make_addr(REGION_SD, 1'b0, int'($urandom_range(31, 16))));
            else
               host_idle();
         end
         3:
         begin
            if (sel < 6)
               host_read(make_addr(REGION_SD, 1'b0, int'($urandom_range(31))));
            else
               host_idle();
         end
         default:
         begin
            if (sel < 3)
               host_write(make_addr(REGION_SD, 1'b1, int'($urandom_range(15))), $urandom());
            else if (sel < 5)
               host_read(make_addr(REGION_RXBUF, 1'b0, int'($urandom_range(15))));
            else if (sel < 6)
               host_read(make_addr(REGION_FB, 1'b0, int'($urandom_range(15))));
            else
               host_idle();
         end
      endcase
   endtask

   initial
   begin
      void'($urandom(4));
      rstn        = 1'b0;
      host_idle();
      key_valid   = 1'b0;
      key_entry   = '0;
      sd_stat     = '0;
      dip         = '0;
      sd_buf_addr = '0;
      sd_tx_rd    = 1'b0;
      sd_rx_wr    = 1'b0;
      sd_rx_data  = '0;
      done        = 1'b0;
      repeat (4) @(posedge msoc_clk);
      #1 rstn = 1'b1;
      for (int p = 0; p < 5; p++)
      begin
         for (int i = 0; i < phase_len(p); i++)
         begin
            @(posedge msoc_clk);
            #1;
            key_step(p == 0 ? 70 : (p == 1 ? 20 : 10));
            engine_step(p == 3);
            host_step(p);
         end
      end
      @(posedge msoc_clk);
      #1;
      host_idle();
      key_valid = 1'b0;
      sd_tx_rd  = 1'b0;
      sd_rx_wr  = 1'b0;
      repeat (4) @(posedge msoc_clk);   // Let the last read data land
      done = 1'b1;
      #1;
      if (err_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: vlog.f
hdl/periph_pkg.sv
hdl/host_decode.sv
hdl/key_fifo.sv
hdl/sd_ctrl_regs.sv
hdl/sd_block_buf.sv
hdl/periph_hub.sv
verif/periph_props.sv
verif/periph_checker.sv
verif/tb_periph_hub.sv
